// File: Makefile
VERILATOR  := verilator
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
TOP        := tb_sig_addsub
FILELIST   := sim.f
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "Test passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: design/adder_if.sv
// Operand and prefix bundles; operand fields mean something only while valid is high
`timescale 1ns/1ps

interface operand_if (
	input logic clk
);
	import adder_pkg::*;

	sig_t a;
	sig_t b;
	logic cin;
	// One-cycle strobe per operation
	logic valid;

	modport src (
		output a,
		output b,
		output cin,
		output valid
	);

	// Clock is only needed here for the adder self-check
	modport dst (
		input clk,
		input a,
		input b,
		input cin,
		input valid
	);

endinterface

// Purely combinational link between pre/post-computation and the prefix network
interface prefix_if;
	import adder_pkg::*;

	prefix_t p;
	prefix_t g;
	carry_t h;
	carry_t c;

	modport tree (
		input p,
		input g,
		output h,
		output c
	);

	modport pre (
		output p,
		output g,
		input h,
		input c
	);

endinterface

// File: design/adder_pkg.sv
// Widths and vector types for the 26-bit significand adder; sized for 24 bits plus guard and round
package adder_pkg;

	// Significand with guard and round bits
	localparam int sig_width = 26;

	// Propagate and generate vectors, position 0 carries the carry-in
	localparam int prefix_width = sig_width + 1;

	// Odd positions handled by the Kogge-Stone part of the tree
	localparam int odd_nodes = sig_width / 2;

	// Levels needed to span all odd positions
	localparam int kogge_levels = $clog2(odd_nodes);

	// Operands and sum
	typedef logic [sig_width-1:0] sig_t;

	// Propagate and generate, bit 0 is the carry-in slot
	typedef logic [prefix_width-1:0] prefix_t;

	// Pseudo-carries and true carries, numbered from 1
	typedef logic [sig_width:1] carry_t;

endpackage

// File: design/han_carlson_tree.sv
// Ling-form Han-Carlson prefix network for 26 bits; position 0 of p/g is the carry-in slot
`timescale 1ns/1ps

module han_carlson_tree (
	prefix_if.tree pf
);
	import adder_pkg::*;

	// Pseudo-carry per odd position, one row per level
	logic [odd_nodes-1:0] hx [0:kogge_levels];

	// Group propagate per odd position, last level needs none
	logic [odd_nodes-1:0] ix [0:kogge_levels-1];

	// Reduced first level, pairs of neighbouring positions
	// Position 1 already reaches the carry-in
	assign hx[0][0] = pf.g[1] | pf.g[0];
	assign ix[0][0] = pf.p[0];

	for (genvar m = 1; m < odd_nodes; m++) begin : g_rblk
		assign hx[0][m] = pf.g[2*m+1] | pf.g[2*m];
		assign ix[0][m] = pf.p[2*m] & pf.p[2*m-1];
	end

	// Kogge-Stone levels on odd positions, spans 2, 4, 8, 16
	for (genvar l = 1; l <= kogge_levels; l++) begin : g_lvl
		for (genvar m = 0; m < odd_nodes; m++) begin : g_node
			if (m >= (1 << (l - 1))) begin : g_cell
				assign hx[l][m] = hx[l-1][m]
					| (ix[l-1][m] & hx[l-1][m - (1 << (l - 1))]);
			end else begin : g_done
				// Already complete down to position 0
				assign hx[l][m] = hx[l-1][m];
			end

			if (l < kogge_levels) begin : g_prop
				if (m >= (1 << (l - 1))) begin : g_and
					assign ix[l][m] = ix[l-1][m] & ix[l-1][m - (1 << (l - 1))];
				end else begin : g_keep
					assign ix[l][m] = ix[l-1][m];
				end
			end
		end
	end

	// Odd pseudo-carries straight from the last level
	for (genvar m = 0; m < odd_nodes; m++) begin : g_odd
		assign pf.h[2*m+1] = hx[kogge_levels][m];
	end

	// Final grey level fills the even positions
	// The top one, position 26, is the pseudo-carry for cout
	for (genvar m = 1; m <= odd_nodes; m++) begin : g_even
		assign pf.h[2*m] = pf.g[2*m] | (pf.p[2*m-1] & pf.h[2*m-1]);
	end

	// True carries, c[k+1] = p[k] & h[k]
	assign pf.c[1] = pf.g[0];

	for (genvar k = 1; k < sig_width; k++) begin : g_carry
		assign pf.c[k+1] = pf.p[k] & pf.h[k];
	end

endmodule

// File: design/ling_adder.sv
// Pre/post-computation around the prefix tree; operands arrive with subtraction already applied
`timescale 1ns/1ps

module ling_adder (
	operand_if.dst          ops,
	prefix_if.pre           pf,
	output adder_pkg::sig_t sum,
	output logic            cout
);
	import adder_pkg::*;

	// Carry-in sits at position 0 and always propagates
	assign pf.p = {ops.a | ops.b, 1'b1};
	assign pf.g = {ops.a & ops.b, ops.cin};

	// Ling sum, with the g & c term covering both operand bits set
	assign sum = (pf.p[prefix_width-1:1] ^ pf.h)
		| (pf.g[prefix_width-1:1] & pf.c);

	// Carry out of the top bit
	assign cout = pf.p[prefix_width-1] & pf.h[sig_width];

	// Whole tree against a plain addition
	property p_total;
		@(posedge ops.clk)
		ops.valid |-> ({cout, sum} == ops.a + ops.b + ops.cin);
	endproperty

	a_total: assert property (p_total)
		else $error("prefix tree result %h differs from a + b + cin", {cout, sum});

endmodule

// File: design/operand_stage.sv
// Operand register; b is inverted and carry-in forced to 1 for subtraction, no back-pressure
`timescale 1ns/1ps

module operand_stage (
	input  logic            clk,
	input  logic            arst_n,
	input  logic            in_valid,
	input  logic            op_sub,
	input  adder_pkg::sig_t a,
	input  adder_pkg::sig_t b,
	input  logic            cin,
	operand_if.src          ops
);

	// Valid strobe, follows in_valid one cycle later
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ops.valid <= 1'b0;
		end else begin
			ops.valid <= in_valid;
		end
	end

	// Data only moves when an operation arrives
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ops.a   <= '0;
			ops.b   <= '0;
			ops.cin <= 1'b0;
		end else if (in_valid) begin
			ops.a <= a;
			// a - b computed as a + ~b + 1
			if (op_sub) begin
				ops.b   <= ~b;
				ops.cin <= 1'b1;
			end else begin
				ops.b   <= b;
				ops.cin <= cin;
			end
		end
	end

	property p_valid_known;
		@(posedge clk) disable iff (!arst_n)
		!$isunknown(ops.valid);
	endproperty

	a_valid_known: assert property (p_valid_known)
		else $error("operand valid is unknown after reset");

endmodule

// File: design/result_stage.sv
// Result register; output is held only for the cycle out_valid is high
`timescale 1ns/1ps

module result_stage (
	input  logic            clk,
	input  logic            arst_n,
	operand_if.dst          ops,
	input  adder_pkg::sig_t sum_in,
	input  logic            cout_in,
	output logic            out_valid,
	output adder_pkg::sig_t sum,
	output logic            cout,
	output logic            zero
);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= ops.valid;
		end
	end

	// Capture only for a live operation
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			sum  <= '0;
			cout <= 1'b0;
			zero <= 1'b0;
		end else if (ops.valid) begin
			sum  <= sum_in;
			cout <= cout_in;
			zero <= ~|sum_in;
		end
	end

	// A presented result must be fully resolved
	property p_result_known;
		@(posedge clk) disable iff (!arst_n)
		out_valid |-> !$isunknown({zero, cout, sum});
	endproperty

	a_result_known: assert property (p_result_known)
		else $error("result has unknown bits: zero %b cout %b sum %h", zero, cout, sum);

endmodule

// File: design/sig_addsub.sv
// Significand add/subtract, 2-cycle fixed latency, one op per clock, results not held
`timescale 1ns/1ps

module sig_addsub (
	input  logic            clk,
	input  logic            arst_n,
	input  logic            in_valid,
	input  logic            op_sub,
	input  adder_pkg::sig_t a,
	input  adder_pkg::sig_t b,
	input  logic            cin,
	output logic            out_valid,
	output adder_pkg::sig_t sum,
	output logic            cout,
	output logic            zero
);
	import adder_pkg::*;

	// Combinational adder result between the two registers
	sig_t sum_comb;
	logic cout_comb;

	operand_if u_ops (
		.clk (clk)
	);

	prefix_if u_pf ();

	operand_stage u_operand_stage (
		.clk      (clk),
		.arst_n   (arst_n),
		.in_valid (in_valid),
		.op_sub   (op_sub),
		.a        (a),
		.b        (b),
		.cin      (cin),
		.ops      (u_ops.src)
	);

	ling_adder u_ling_adder (
		.ops  (u_ops.dst),
		.pf   (u_pf.pre),
		.sum  (sum_comb),
		.cout (cout_comb)
	);

	han_carlson_tree u_han_carlson_tree (
		.pf (u_pf.tree)
	);

	result_stage u_result_stage (
		.clk       (clk),
		.arst_n    (arst_n),
		.ops       (u_ops.dst),
		.sum_in    (sum_comb),
		.cout_in   (cout_comb),
		.out_valid (out_valid),
		.sum       (sum),
		.cout      (cout),
		.zero      (zero)
	);

endmodule

// File: sim.f
design/adder_pkg.sv
design/adder_if.sv
design/operand_stage.sv
design/han_carlson_tree.sv
design/ling_adder.sv
design/result_stage.sv
design/sig_addsub.sv
tb/tb_clock.sv
tb/adder_checker.sv
tb/tb_sig_addsub.sv

// File: tb/adder_checker.sv
// Samples DUT outputs on the falling edge; expects results in issue order with 2-cycle latency
`timescale 1ns/1ps

module adder_checker (
	input logic            clk,
	input logic            arst_n,
	input logic            in_valid,
	input logic            out_valid,
	input adder_pkg::sig_t sum,
	input logic            cout,
	input logic            zero
);
	import adder_pkg::*;

	// Queued expectations, {zero, cout, sum}
	logic [sig_width+1:0] exp_q [$];
	logic [sig_width+1:0] exp_word;

	int pending = 0;
	int err_count = 0;
	int checked = 0;

	// in_valid seen on the last two falling edges
	logic [1:0] valid_hist = 2'b00;

	task automatic push_expected(
		input sig_t e_sum,
		input logic e_cout,
		input logic e_zero
	);
		exp_q.push_back({e_zero, e_cout, e_sum});
		pending = exp_q.size();
	endtask

	always @(negedge clk) begin
		// out_valid must be in_valid delayed by exactly two cycles
		if (out_valid !== valid_hist[1]) begin
			$display("ERR t=%0t out_valid expected %b got %b", $time, valid_hist[1], out_valid);
			err_count++;
		end

		if (out_valid === 1'b1) begin
			if (exp_q.size() == 0) begin
				$display("Result at %0t arrived with no operation outstanding", $time);
				err_count++;
			end else begin
				exp_word = exp_q.pop_front();
				pending = exp_q.size();
				checked++;
				if (sum !== exp_word[sig_width-1:0]) begin
					$display("ERR t=%0t sum expected %h got %h",
						$time, exp_word[sig_width-1:0], sum);
					err_count++;
				end
				if (cout !== exp_word[sig_width]) begin
					$display("ERR t=%0t cout expected %b got %b",
						$time, exp_word[sig_width], cout);
					err_count++;
				end
				if (zero !== exp_word[sig_width+1]) begin
					$display("ERR t=%0t zero expected %b got %b",
						$time, exp_word[sig_width+1], zero);
					err_count++;
				end
			end
		end

		// Nothing can enter the pipeline while reset is held
		valid_hist = {valid_hist[0], (arst_n === 1'b1) ? in_valid : 1'b0};
	end

endmodule

// File: tb/adder_input.txt
// Columns in hex: op_sub a b cin, then expected sum cout zero
// One operation per line, 26-bit operands
0 0000000 0000000 0 0000000 0 1
0 3ffffff 0000000 1 0000000 1 1
0 3ffffff 0000001 0 0000000 1 1
0 2aaaaaa 1555555 0 3ffffff 0 0
0 2aaaaaa 1555555 1 0000000 1 1
0 2aaaaaa 2aaaaaa 0 1555554 1 0
0 1555555 1555555 1 2aaaaab 0 0
0 0000001 3ffffff 0 0000000 1 1
0 1234567 0abcdef 0 1cf1356 0 0
0 3ffffff 3ffffff 1 3ffffff 1 0
0 0000000 0000000 1 0000001 0 0
0 0ffffff 0000001 0 1000000 0 0
1 1234567 1234567 0 0000000 1 1
1 1234567 1234567 1 0000000 1 1
1 0000005 0000007 0 3fffffe 0 0
1 0000000 0000001 1 3ffffff 0 0
1 3ffffff 0000001 0 3fffffe 1 0
1 2000000 0000001 0 1ffffff 1 0
1 0000000 0000000 0 0000000 1 1

// File: tb/tb_clock.sv
// Free-running 8 ns clock from time 0; arst_n low for the first 10 rising edges
`timescale 1ns/1ps

module tb_clock (
	output logic clk,
	output logic arst_n
);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin
		arst_n = 1'b0;
		repeat (10) @(posedge clk);
		arst_n <= 1'b1;
	end

endmodule

// File: tb/tb_sig_addsub.sv
// Directed vectors come from tb/adder_input.txt (run from project root), then LFSR random traffic
`timescale 1ns/1ps

module tb_sig_addsub;

	localparam int sig_bits = 26;
	localparam int vec_cols = 7;
	localparam int max_vecs = 64;

	logic clk;
	logic arst_n;
	logic in_valid;
	logic op_sub;
	logic [sig_bits-1:0] a;
	logic [sig_bits-1:0] b;
	logic cin;
	logic out_valid;
	logic [sig_bits-1:0] sum;
	logic cout;
	logic zero;

	logic [31:0] vec_mem [0:vec_cols*max_vecs-1];
	logic [31:0] lfsr_state;
	bit run_aborted;
	int tests_ok;
	int tests_bad;
	int errs_before;

	tb_clock u_tb_clock (
		.clk    (clk),
		.arst_n (arst_n)
	);

	sig_addsub u_sig_addsub (
		.clk       (clk),
		.arst_n    (arst_n),
		.in_valid  (in_valid),
		.op_sub    (op_sub),
		.a         (a),
		.b         (b),
		.cin       (cin),
		.out_valid (out_valid),
		.sum       (sum),
		.cout      (cout),
		.zero      (zero)
	);

	adder_checker u_adder_checker (
		.clk       (clk),
		.arst_n    (arst_n),
		.in_valid  (in_valid),
		.out_valid (out_valid),
		.sum       (sum),
		.cout      (cout),
		.zero      (zero)
	);

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_state[31]};
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	// {cout, sum} of a plus effective operand plus effective carry
	function automatic logic [sig_bits:0] reference_total(
		input logic                sub,
		input logic [sig_bits-1:0] x,
		input logic [sig_bits-1:0] y,
		input logic                c
	);
		logic [sig_bits-1:0] y_eff;
		logic c_eff;
		y_eff = sub ? ~y : y;
		c_eff = sub ? 1'b1 : c;
		return {1'b0, x} + {1'b0, y_eff} + {{sig_bits{1'b0}}, c_eff};
	endfunction

	task automatic drive_op(
		input logic                sub,
		input logic [sig_bits-1:0] x,
		input logic [sig_bits-1:0] y,
		input logic                c,
		input logic [sig_bits-1:0] e_sum,
		input logic                e_cout,
		input logic                e_zero
	);
		@(posedge clk);
		in_valid <= 1'b1;
		op_sub   <= sub;
		a        <= x;
		b        <= y;
		cin      <= c;
		u_adder_checker.push_expected(e_sum, e_cout, e_zero);
	endtask

	task automatic drive_idle(input int n);
		repeat (n) begin
			@(posedge clk);
			in_valid <= 1'b0;
		end
	endtask

	task automatic drive_random_op();
		logic [31:0] r_sub;
		logic [31:0] r_a;
		logic [31:0] r_b;
		logic [31:0] r_cin;
		logic [sig_bits:0] total;
		take_bits(1, r_sub);
		take_bits(sig_bits, r_a);
		take_bits(sig_bits, r_b);
		take_bits(1, r_cin);
		total = reference_total(r_sub[0], r_a[sig_bits-1:0], r_b[sig_bits-1:0], r_cin[0]);
		drive_op(r_sub[0], r_a[sig_bits-1:0], r_b[sig_bits-1:0], r_cin[0],
			total[sig_bits-1:0], total[sig_bits], total[sig_bits-1:0] == '0);
	endtask

	task automatic run_directed();
		int v;
		int base;
		v = 0;
		base = 0;
		while (v < max_vecs && vec_mem[base] !== 32'hffffffff) begin
			drive_op(vec_mem[base][0], vec_mem[base+1][sig_bits-1:0],
				vec_mem[base+2][sig_bits-1:0], vec_mem[base+3][0],
				vec_mem[base+4][sig_bits-1:0], vec_mem[base+5][0], vec_mem[base+6][0]);
			v++;
			base = v * vec_cols;
		end
		if (v == 0) begin
			$display("No vectors could be read from tb/adder_input.txt");
			run_aborted = 1'b1;
		end
	endtask

	task automatic wait_reset_release(input int limit);
		int n;
		n = 0;
		while (arst_n !== 1'b1 && n < limit) begin
			@(posedge clk);
			n++;
		end
		if (arst_n !== 1'b1) begin
			$display("Reset was still asserted after %0d cycles", limit);
			run_aborted = 1'b1;
		end
	endtask

	task automatic wait_drain(input int limit);
		int n;
		n = 0;
		while (u_adder_checker.pending != 0 && n < limit) begin
			@(posedge clk);
			n++;
		end
		if (u_adder_checker.pending != 0) begin
			$display("Pipeline stalled with %0d results still outstanding after %0d cycles",
				u_adder_checker.pending, limit);
			run_aborted = 1'b1;
		end
	endtask

	task automatic finish_test(input string name);
		int errs;
		errs = u_adder_checker.err_count - errs_before;
		if (errs == 0 && !run_aborted) begin
			tests_ok++;
			$display("%s: ok", name);
		end else begin
			tests_bad++;
			$display("%s: FAILED with %0d errors", name, errs);
		end
		errs_before = u_adder_checker.err_count;
	endtask

	initial begin
		logic [31:0] gap;
		in_valid = 1'b0;
		op_sub = 1'b0;
		a = '0;
		b = '0;
		cin = 1'b0;
		lfsr_state = 32'h29dda8b4;
		run_aborted = 1'b0;
		tests_ok = 0;
		tests_bad = 0;
		errs_before = 0;
		for (int i = 0; i < vec_cols * max_vecs; i++) begin
			vec_mem[i] = 32'hffffffff;
		end
		$readmemh("tb/adder_input.txt", vec_mem);

		wait_reset_release(20);
		drive_idle(8);
		finish_test("reset and idle");

		if (!run_aborted) begin
			run_directed();
			drive_idle(1);
			wait_drain(10);
			finish_test("directed add, subtract and carry chain");
		end

		if (!run_aborted) begin
			repeat (200) drive_random_op();
			drive_idle(1);
			wait_drain(10);
			finish_test("back-to-back random");
		end

		if (!run_aborted) begin
			repeat (100) begin
				drive_random_op();
				take_bits(2, gap);
				drive_idle(gap[1:0]);
			end
			drive_idle(1);
			wait_drain(10);
			drive_idle(4);
			finish_test("random with idle gaps");
		end

		$display("Summary: %0d tests ok, %0d tests failing, %0d results checked, %0d errors",
			tests_ok, tests_bad, u_adder_checker.checked, u_adder_checker.err_count);
		if (run_aborted || tests_bad != 0 || u_adder_checker.err_count != 0) begin
			$display("Test failed");
		end else begin
			$display("Test passed");
		end
		$finish;
	end

endmodule
